//--- hw/uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

    // ##################################################
    // Channel and baud constants
    // ##################################################
    localparam int NUM_CHANNELS = 4;
    localparam int BAUD_DIV     = 8;                  // Clock cycles per bit period
    localparam int BAUD_CNT_W   = $clog2(BAUD_DIV);
    localparam logic [BAUD_CNT_W-1:0] BAUD_LAST = BAUD_CNT_W'(BAUD_DIV - 1);

    localparam int FRAME_MAX    = 12;                 // Start + 8 data + parity + 2 stop

    // ##################################################
    // Frame format
    // ##################################################
    typedef enum logic [1:0] {
        BITS_5 = 2'b00,
        BITS_6 = 2'b01,
        BITS_7 = 2'b10,
        BITS_8 = 2'b11
    } data_bits_e;

    typedef struct packed {
        data_bits_e data_bits;
        logic       parity_en;
        logic       parity_odd;                       // 0 even, 1 odd
        logic       two_stop;
    } frame_cfg_t;

    localparam frame_cfg_t CFG_RESET = '{
        data_bits:  BITS_8,
        parity_en:  1'b0,
        parity_odd: 1'b0,
        two_stop:   1'b0
    };

endpackage

`default_nettype wire

//--- hw/uart_host_pkg.sv
`default_nettype none

package uart_host_pkg;

    localparam int CHAN_W = $clog2(uart_frame_pkg::NUM_CHANNELS);

    typedef enum logic [1:0] {
        CMD_DATA  = 2'b00,
        CMD_CFG   = 2'b01,
        CMD_CLEAR = 2'b10
    } cmd_kind_e;

    // ##################################################
    // Command word views
    // ##################################################
    typedef struct packed {
        cmd_kind_e         kind;
        logic [CHAN_W-1:0] chan;
        logic [3:0]        rsvd;
        logic [7:0]        payload;
    } cmd_data_t;

    typedef struct packed {
        cmd_kind_e                 kind;
        logic [CHAN_W-1:0]         chan;
        logic [6:0]                rsvd;
        uart_frame_pkg::frame_cfg_t cfg;
    } cmd_cfg_t;

    typedef union packed {
        cmd_data_t data;
        cmd_cfg_t  cfg;
    } cmd_word_u;

    typedef struct packed {
        logic [uart_frame_pkg::NUM_CHANNELS-1:0] busy;
        logic [uart_frame_pkg::NUM_CHANNELS-1:0] done;
        logic                                    drop;
    } tx_status_t;

endpackage

`default_nettype wire

//--- hw/baud_tick_gen.sv
`timescale 1ns/1ns
`default_nettype none

module baud_tick_gen (
    input  logic clk,
    input  logic reset_n,
    output logic tick_o
);

    logic [uart_frame_pkg::BAUD_CNT_W-1:0] cnt_q;
    logic                                  wrap;

    assign wrap = (cnt_q == uart_frame_pkg::BAUD_LAST);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt_q <= '0;
        end else if (wrap) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // First tick lands BAUD_DIV cycles after reset release
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tick_o <= 1'b0;
        end else begin
            tick_o <= wrap;
        end
    end

    a_tick_single: assert property (
        @(posedge clk) disable iff (!reset_n)
        tick_o |=> !tick_o
    ) else $error("baud tick high on two consecutive cycles");

endmodule

`default_nettype wire

//--- hw/tx_cmd_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module tx_cmd_decoder (
    input  logic                                                   clk,
    input  logic                                                   reset_n,
    input  logic                                                   cmd_valid_i,
    input  uart_host_pkg::cmd_word_u                               cmd_i,
    input  logic [uart_frame_pkg::NUM_CHANNELS-1:0]                busy_i,
    output logic [uart_frame_pkg::NUM_CHANNELS-1:0]                start_tx_o,
    output logic [7:0]                                             payload_o,
    output uart_frame_pkg::frame_cfg_t [uart_frame_pkg::NUM_CHANNELS-1:0] cfg_o,
    output logic                                                   drop_o,
    output logic                                                   clear_o
);

    uart_host_pkg::cmd_kind_e                                kind;
    logic [uart_frame_pkg::NUM_CHANNELS-1:0]                 chan_sel;
    logic [uart_frame_pkg::NUM_CHANNELS-1:0]                 start_d;
    logic [uart_frame_pkg::NUM_CHANNELS-1:0]                 busy_eff;
    logic [uart_frame_pkg::NUM_CHANNELS-1:0]                 pend_valid;
    uart_frame_pkg::frame_cfg_t [uart_frame_pkg::NUM_CHANNELS-1:0] pend_cfg;
    logic                                                    is_data;
    logic                                                    is_cfg;

    assign kind    = cmd_i.data.kind;                 // Shared by both views
    assign is_data = cmd_valid_i && (kind == uart_host_pkg::CMD_DATA);
    assign is_cfg  = cmd_valid_i && (kind == uart_host_pkg::CMD_CFG);

    always_comb begin
        chan_sel = '0;
        chan_sel[cmd_i.data.chan] = cmd_valid_i;
    end

    // Local load strobes cover the two cycles before collector busy rises
    assign busy_eff = busy_i | start_tx_o | start_d;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            start_tx_o <= '0;
            start_d    <= '0;
            drop_o     <= 1'b0;
            clear_o    <= 1'b0;
        end else begin
            start_tx_o <= is_data ? (chan_sel & ~busy_eff) : '0;
            start_d    <= start_tx_o;
            drop_o     <= is_data && |(chan_sel & busy_eff);
            clear_o    <= cmd_valid_i && (kind == uart_host_pkg::CMD_CLEAR);
        end
    end

    always_ff @(posedge clk) begin
        if (is_data) begin
            payload_o <= cmd_i.data.payload;
        end
        for (int ch = 0; ch < uart_frame_pkg::NUM_CHANNELS; ch++) begin
            if (is_cfg && chan_sel[ch]) begin
                pend_cfg[ch] <= cmd_i.cfg.cfg;
            end
        end
    end

    // ##################################################
    // Per-channel frame config deferred while busy
    // ##################################################
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cfg_o      <= {uart_frame_pkg::NUM_CHANNELS{uart_frame_pkg::CFG_RESET}};
            pend_valid <= '0;
        end else begin
            for (int ch = 0; ch < uart_frame_pkg::NUM_CHANNELS; ch++) begin
                if (is_cfg && chan_sel[ch]) begin
                    if (busy_eff[ch]) begin
                        pend_valid[ch] <= 1'b1;
                    end else begin
                        cfg_o[ch]      <= cmd_i.cfg.cfg;
                        pend_valid[ch] <= 1'b0;
                    end
                end else if (pend_valid[ch] && !busy_eff[ch]) begin
                    cfg_o[ch]      <= pend_cfg[ch];
                    pend_valid[ch] <= 1'b0;
                end
            end
        end
    end

    a_start_onehot: assert property (
        @(posedge clk) disable iff (!reset_n)
        $onehot0(start_tx_o)
    ) else $error("more than one load strobe in a cycle");

endmodule

`default_nettype wire

//--- hw/transmitter_controller.sv
`timescale 1ns/1ns
`default_nettype none

module transmitter_controller (
    input  logic clk,
    input  logic reset_n,
    input  logic start_tx_i,
    input  logic tick_i,
    input  logic data_fi_i,
    input  logic stop_fi_i,
    input  logic parity_en_i,
    output logic trans_en_o,
    output logic tx_finish_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_TICK,
        SHIFT,
        FINISH
    } state_e;

    state_e state_q;
    state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_tx_i) state_d = WAIT_TICK;
            end
            WAIT_TICK: begin
                if (tick_i) state_d = SHIFT;  // Start bit goes out on this tick
            end
            SHIFT: begin
                if (tick_i && stop_fi_i) state_d = FINISH;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign trans_en_o  = (state_q == WAIT_TICK) || (state_q == SHIFT);
    assign tx_finish_o = (state_q == FINISH);

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!reset_n)
        start_tx_i |-> !trans_en_o
    ) else $error("load strobe while frame in progress");

    // With parity on, the bit after the last data bit is never the last stop bit
    a_parity_slot: assert property (
        @(posedge clk) disable iff (!reset_n)
        (state_q == SHIFT && tick_i && data_fi_i && parity_en_i) |=> !stop_fi_i
    ) else $error("parity bit slot missing from frame");

endmodule

`default_nettype wire

//--- hw/uart_transmitter.sv
`timescale 1ns/1ns
`default_nettype none

module uart_transmitter (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       start_tx_i,
    input  logic                       tick_i,
    input  logic [7:0]                 data_i,
    input  uart_frame_pkg::frame_cfg_t cfg_i,
    output logic                       tx_o,
    output logic                       busy_o,
    output logic                       finish_o
);

    logic [7:0]                           data_q;
    uart_frame_pkg::frame_cfg_t           cfg_q;
    logic [3:0]                           data_size;
    logic [3:0]                           frame_len;
    logic [7:0]                           pad_mask;
    logic [7:0]                           data_pad;
    logic                                 parity_bit;
    logic [uart_frame_pkg::FRAME_MAX-1:0] frame;
    logic [uart_frame_pkg::FRAME_MAX-1:0] sr_q;
    logic [3:0]                           cnt_q;
    logic                                 trans_en;
    logic                                 shift_en;
    logic                                 data_fi;
    logic                                 stop_fi;

    always_ff @(posedge clk) begin
        if (start_tx_i) begin
            data_q <= data_i;
            cfg_q  <= cfg_i;
        end
    end

    // ##################################################
    // Frame builder
    // ##################################################
    assign data_size = 4'd5 + {2'b00, cfg_q.data_bits};
    assign frame_len = 4'd1 + data_size + {3'b000, cfg_q.parity_en}
                     + (cfg_q.two_stop ? 4'd2 : 4'd1);

    assign pad_mask   = 8'hFF << data_size;
    assign data_pad   = data_q | pad_mask;              // Unused upper bits sent as ones
    assign parity_bit = ^(data_q & ~pad_mask) ^ cfg_q.parity_odd;

    always_comb begin
        frame      = '1;                                // Stop bits and idle fill
        frame[0]   = 1'b0;                              // Start bit
        frame[8:1] = data_pad;
        if (cfg_q.parity_en) begin
            frame[4'd1 + data_size] = parity_bit;
        end
    end

    // ##################################################
    // Bit counter and shift register
    // ##################################################
    assign shift_en = trans_en && tick_i;
    assign data_fi  = (cnt_q == 4'd1 + data_size);      // Last data bit on the line
    assign stop_fi  = (cnt_q == frame_len);             // Last stop bit on the line

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt_q <= '0;
        end else if (shift_en) begin
            cnt_q <= cnt_q + 1'b1;
        end else if (!trans_en) begin
            cnt_q <= '0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sr_q <= '1;
        end else if (shift_en) begin
            if (cnt_q == 4'd0) begin
                sr_q <= frame;                          // Load on the first tick
            end else begin
                sr_q <= {1'b1, sr_q[uart_frame_pkg::FRAME_MAX-1:1]};
            end
        end
    end

    assign tx_o   = sr_q[0];
    assign busy_o = trans_en;

    transmitter_controller u_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .start_tx_i  (start_tx_i),
        .tick_i      (tick_i),
        .data_fi_i   (data_fi),
        .stop_fi_i   (stop_fi),
        .parity_en_i (cfg_q.parity_en),
        .trans_en_o  (trans_en),
        .tx_finish_o (finish_o)
    );

endmodule

`default_nettype wire

//--- hw/tx_status_collector.sv
`timescale 1ns/1ns
`default_nettype none

module tx_status_collector (
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  logic [uart_frame_pkg::NUM_CHANNELS-1:0] busy_i,
    input  logic [uart_frame_pkg::NUM_CHANNELS-1:0] finish_i,
    input  logic                                    drop_i,
    input  logic                                    clear_i,
    output logic [uart_frame_pkg::NUM_CHANNELS-1:0] busy_o,
    output uart_host_pkg::tx_status_t               status_o,
    output logic                                    done_irq_o
);

    logic [uart_frame_pkg::NUM_CHANNELS-1:0] busy_q;
    logic [uart_frame_pkg::NUM_CHANNELS-1:0] done_q;
    logic                                    drop_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q <= '0;
            done_q <= '0;
            drop_q <= 1'b0;
        end else begin
            busy_q <= busy_i;
            // New events beat a clear in the same cycle
            done_q <= (clear_i ? '0 : done_q) | finish_i;
            drop_q <= (clear_i ? 1'b0 : drop_q) | drop_i;
        end
    end

    assign busy_o = busy_q;

    always_comb begin
        status_o.busy = busy_q;
        status_o.done = done_q;
        status_o.drop = drop_q;
    end

    assign done_irq_o = |done_q;                        // Level while any done is set

endmodule

`default_nettype wire

//--- hw/multi_uart_tx_top.sv
`timescale 1ns/1ns
`default_nettype none

module multi_uart_tx_top (
    input  logic                                    clk,
    input  logic                                    reset_n,
    input  logic                                    cmd_valid_i,
    input  uart_host_pkg::cmd_word_u                cmd_i,
    output logic [uart_frame_pkg::NUM_CHANNELS-1:0] tx_o,
    output uart_host_pkg::tx_status_t               status_o,
    output logic                                    done_irq_o
);

    logic                                                    tick;
    logic [uart_frame_pkg::NUM_CHANNELS-1:0]                 start_tx;
    logic [7:0]                                              payload;
    uart_frame_pkg::frame_cfg_t [uart_frame_pkg::NUM_CHANNELS-1:0] cfg;
    logic                                                    drop;
    logic                                                    clear;
    logic [uart_frame_pkg::NUM_CHANNELS-1:0]                 tx_busy;
    logic [uart_frame_pkg::NUM_CHANNELS-1:0]                 tx_finish;
    logic [uart_frame_pkg::NUM_CHANNELS-1:0]                 busy_seen;

    baud_tick_gen u_baud (
        .clk     (clk),
        .reset_n (reset_n),
        .tick_o  (tick)
    );

    tx_cmd_decoder u_dec (
        .clk         (clk),
        .reset_n     (reset_n),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .busy_i      (busy_seen),
        .start_tx_o  (start_tx),
        .payload_o   (payload),
        .cfg_o       (cfg),
        .drop_o      (drop),
        .clear_o     (clear)
    );

    // ##################################################
    // One transmitter per channel
    // ##################################################
    for (genvar ch = 0; ch < uart_frame_pkg::NUM_CHANNELS; ch++) begin : g_chan
        uart_transmitter u_tx (
            .clk        (clk),
            .reset_n    (reset_n),
            .start_tx_i (start_tx[ch]),
            .tick_i     (tick),
            .data_i     (payload),
            .cfg_i      (cfg[ch]),
            .tx_o       (tx_o[ch]),
            .busy_o     (tx_busy[ch]),
            .finish_o   (tx_finish[ch])
        );
    end

    tx_status_collector u_stat (
        .clk        (clk),
        .reset_n    (reset_n),
        .busy_i     (tx_busy),
        .finish_i   (tx_finish),
        .drop_i     (drop),
        .clear_i    (clear),
        .busy_o     (busy_seen),
        .status_o   (status_o),
        .done_irq_o (done_irq_o)
    );

endmodule

`default_nettype wire

//--- test/tb_multi_uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module tb_multi_uart_tx;

    localparam int NUM_CH      = uart_frame_pkg::NUM_CHANNELS;
    localparam int BAUD_DIV    = uart_frame_pkg::BAUD_DIV;
    localparam int FRAME_MAX   = 12;
    localparam int CLK_PERIOD  = 40;
    localparam int NUM_FRAMES  = 43;                    // Data frames over all tests
    localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_MAX * BAUD_DIV * CLK_PERIOD * 4 + 20000;
    localparam int FRAME_WAIT  = 2 * FRAME_MAX * BAUD_DIV;

    logic                       clk = 1'b0;
    logic                       reset_n;
    logic                       cmd_valid;
    uart_host_pkg::cmd_word_u   cmd;
    logic [NUM_CH-1:0]          tx;
    uart_host_pkg::tx_status_t  status;
    logic                       done_irq;

    logic [FRAME_MAX-1:0]       cap_bits [NUM_CH];
    int                         cap_len [NUM_CH];
    int                         cap_cnt [NUM_CH];
    int                         chk_cnt [NUM_CH];
    int                         exp_cnt [NUM_CH];
    logic [FRAME_MAX-1:0]       exp_bits [NUM_CH][64];
    int                         exp_len [NUM_CH][64];
    uart_frame_pkg::frame_cfg_t cur_cfg [NUM_CH];
    int                         seed;
    int                         tb_errs;
    int                         cmp_errs;
    int                         err_base;
    int                         tests_run;
    int                         tests_failed;
    string                      test_name;

    always #(CLK_PERIOD / 2) clk = ~clk;

    multi_uart_tx_top uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .tx_o        (tx),
        .status_o    (status),
        .done_irq_o  (done_irq)
    );

    // Start, LSB-first data, optional parity, then stop bits and idle ones
    function automatic logic [FRAME_MAX-1:0] frame_bits(input logic [7:0] payload,
                                                        input uart_frame_pkg::frame_cfg_t cfg);
        logic [FRAME_MAX-1:0] bits;
        logic                 par;
        int                   nbits;
        nbits   = 5 + int'(cfg.data_bits);
        bits    = '1;
        bits[0] = 1'b0;
        par     = cfg.parity_odd;
        for (int i = 0; i < nbits; i++) begin
            bits[i + 1] = payload[i];
            par         = par ^ payload[i];
        end
        if (cfg.parity_en) begin
            bits[nbits + 1] = par;
        end
        return bits;
    endfunction

    // Busy cycles seen from the start edge, one more for the collector register
    function automatic int frame_cycles(input uart_frame_pkg::frame_cfg_t cfg);
        int len;
        len = 1 + 5 + int'(cfg.data_bits) + int'(cfg.parity_en) + (cfg.two_stop ? 2 : 1);
        return len * BAUD_DIV + 1;
    endfunction

    // ##################################################
    // Line monitors and frame checker
    // ##################################################
    for (genvar g = 0; g < NUM_CH; g++) begin : g_mon
        logic [FRAME_MAX-1:0] line_bits;
        int                   line_cnt = 0;
        int                   busy_len = 0;

        always begin : watch_line
            int n;
            @(negedge tx[g]);
            n = 0;
            for (int c = 0; c < (FRAME_MAX + 1) * BAUD_DIV; c++) begin
                @(negedge clk);
                if (c % BAUD_DIV == BAUD_DIV / 2 - 1 && c < FRAME_MAX * BAUD_DIV) begin
                    line_bits[c / BAUD_DIV] = tx[g];      // Middle of each bit period
                end
                if (status.busy[g]) begin
                    n++;
                end
            end
            busy_len = n;
            line_cnt = line_cnt + 1;
        end

        assign cap_bits[g] = line_bits;
        assign cap_len[g]  = busy_len;
        assign cap_cnt[g]  = line_cnt;
    end

    always @(posedge clk) begin : compare_frames
        if (!reset_n) begin
            cmp_errs = 0;
            for (int ch = 0; ch < NUM_CH; ch++) begin
                chk_cnt[ch] = 0;
            end
        end else begin
            for (int ch = 0; ch < NUM_CH; ch++) begin
                if (cap_cnt[ch] != chk_cnt[ch]) begin
                    assert (chk_cnt[ch] < exp_cnt[ch]) else begin
                        $display("ERROR channel %0d: frame on the line with no data sent", ch);
                        cmp_errs++;
                    end
                    if (chk_cnt[ch] < exp_cnt[ch]) begin
                        assert (cap_bits[ch] == exp_bits[ch][chk_cnt[ch]]) else begin
                            $display("MISMATCH tx_o[%0d] frame %0d: expected 0x%03h, got 0x%03h",
                                     ch, chk_cnt[ch], exp_bits[ch][chk_cnt[ch]], cap_bits[ch]);
                            cmp_errs++;
                        end
                        assert (cap_len[ch] == exp_len[ch][chk_cnt[ch]]) else begin
                            $display(
                                "MISMATCH status_o.busy[%0d] cycles: expected 0x%0h, got 0x%0h",
                                ch, exp_len[ch][chk_cnt[ch]], cap_len[ch]);
                            cmp_errs++;
                        end
                    end
                    chk_cnt[ch] = chk_cnt[ch] + 1;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("ERROR watchdog expired before the tests completed");
        $display("Testbench failed");
        $finish;
    end

    // ##################################################
    // Command helpers and checks
    // ##################################################
    function automatic uart_host_pkg::cmd_word_u data_cmd(input int ch, input logic [7:0] p);
        uart_host_pkg::cmd_word_u w;
        w              = '0;
        w.data.kind    = uart_host_pkg::CMD_DATA;
        w.data.chan    = ch[uart_host_pkg::CHAN_W-1:0];
        w.data.payload = p;
        return w;
    endfunction

    function automatic uart_host_pkg::cmd_word_u cfg_cmd(input int ch,
                                                        input uart_frame_pkg::frame_cfg_t c);
        uart_host_pkg::cmd_word_u w;
        w          = '0;
        w.cfg.kind = uart_host_pkg::CMD_CFG;
        w.cfg.chan = ch[uart_host_pkg::CHAN_W-1:0];
        w.cfg.cfg  = c;
        return w;
    endfunction

    function automatic int total_errs();
        return tb_errs + cmp_errs;
    endfunction

    task automatic send_cmd(input uart_host_pkg::cmd_word_u w);   // Called on a falling edge
        cmd       = w;
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic send_frame(input int ch, input logic [7:0] p);
        exp_bits[ch][exp_cnt[ch]] = frame_bits(p, cur_cfg[ch]);
        exp_len[ch][exp_cnt[ch]]  = frame_cycles(cur_cfg[ch]);
        exp_cnt[ch]               = exp_cnt[ch] + 1;
        send_cmd(data_cmd(ch, p));
    endtask

    task automatic send_clear();
        uart_host_pkg::cmd_word_u w;
        w           = '0;
        w.data.kind = uart_host_pkg::CMD_CLEAR;
        send_cmd(w);
        repeat (2) @(negedge clk);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        assert (got === want) else begin
            $display("MISMATCH %s: expected 0x%0h, got 0x%0h", name, want, got);
            tb_errs++;
        end
    endtask

    task automatic wait_frames(input int ch);
        int cycles;
        cycles = 0;
        while (chk_cnt[ch] != exp_cnt[ch] && cycles < FRAME_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (chk_cnt[ch] == exp_cnt[ch]) else begin
            $display("ERROR channel %0d: expected frame never arrived on the line", ch);
            tb_errs++;
        end
        cycles = 0;
        while (status.busy[ch] && cycles < FRAME_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        assert (!status.busy[ch]) else begin
            $display("ERROR channel %0d: busy stayed high after the frame", ch);
            tb_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_base  = total_errs();
    endtask

    task automatic report_test();
        tests_run++;
        if (total_errs() == err_base) begin
            $display("PASS  %s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL  %s (%0d errors)", test_name, total_errs() - err_base);
        end
    endtask

    // ##################################################
    // Test sequence
    // ##################################################
    initial begin : run_tests
        int                         ch;
        int                         cycles;
        uart_frame_pkg::frame_cfg_t cfg;
        seed         = 51833;
        reset_n      = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        tb_errs      = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int c = 0; c < NUM_CH; c++) begin
            exp_cnt[c] = 0;
            cur_cfg[c] = '{data_bits: uart_frame_pkg::BITS_8, parity_en: 1'b0,
                           parity_odd: 1'b0, two_stop: 1'b0};      // 8N1 after reset
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        begin_test("reset format 8N1 on each channel");
        for (int c = 0; c < NUM_CH; c++) begin
            send_frame(c, 8'($random(seed)));
            wait_frames(c);
        end
        report_test();

        begin_test("all 32 frame formats on random channels");
        for (int k = 0; k < 32; k++) begin
            ch  = $random(seed) & 3;
            cfg = uart_frame_pkg::frame_cfg_t'(5'(k));
            send_cmd(cfg_cmd(ch, cfg));
            cur_cfg[ch] = cfg;
            send_frame(ch, 8'($random(seed)));
            wait_frames(ch);
        end
        report_test();

        begin_test("four channels loaded in consecutive cycles");
        for (int c = 0; c < NUM_CH; c++) begin
            send_frame(c, 8'($random(seed)));
        end
        cycles = 0;
        while (status.busy != 4'hF && cycles < 2 * BAUD_DIV) begin
            @(negedge clk);
            cycles++;
        end
        expect_equal("status_o.busy", 32'(status.busy), 32'h0000000F);
        for (int c = 0; c < NUM_CH; c++) begin
            wait_frames(c);
        end
        report_test();

        begin_test("data to a busy channel is dropped");
        send_frame(2, 8'($random(seed)));
        send_cmd(data_cmd(2, 8'($random(seed))));
        wait_frames(2);
        repeat (FRAME_WAIT) @(negedge clk);
        assert (cap_cnt[2] == exp_cnt[2]) else begin
            $display("ERROR channel 2: the dropped data word was sent anyway");
            tb_errs++;
        end
        expect_equal("status_o.drop", 32'(status.drop), 32'h00000001);
        report_test();

        begin_test("done flags, interrupt and clear");
        send_clear();
        expect_equal("status_o.done", 32'(status.done), 32'h00000000);
        expect_equal("done_irq_o", 32'(done_irq), 32'h00000000);
        send_frame(1, 8'($random(seed)));
        send_cmd(data_cmd(1, 8'($random(seed))));
        send_frame(3, 8'($random(seed)));
        cycles = 0;
        while (tx[1] && cycles < FRAME_WAIT) begin
            @(negedge clk);
            cycles++;
        end
        expect_equal("status_o.busy[1]", 32'(status.busy[1]), 32'h00000001);
        wait_frames(1);
        wait_frames(3);
        expect_equal("status_o.done", 32'(status.done), 32'h0000000A);
        expect_equal("status_o.drop", 32'(status.drop), 32'h00000001);
        expect_equal("done_irq_o", 32'(done_irq), 32'h00000001);
        send_clear();
        expect_equal("status_o.done", 32'(status.done), 32'h00000000);
        expect_equal("status_o.drop", 32'(status.drop), 32'h00000000);
        expect_equal("done_irq_o", 32'(done_irq), 32'h00000000);
        report_test();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 total_errs());
        if (total_errs() == 0 && tests_failed == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
hw/uart_frame_pkg.sv
hw/uart_host_pkg.sv
hw/baud_tick_gen.sv
hw/tx_cmd_decoder.sv
hw/transmitter_controller.sv
hw/uart_transmitter.sv
hw/tx_status_collector.sv
hw/multi_uart_tx_top.sv
test/tb_multi_uart_tx.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_multi_uart_tx -Mdir obj_dir -f sim.f \
    && ./obj_dir/Vtb_multi_uart_tx > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "^Testbench passed$" sim.log && echo "Result: PASS" \
    || { echo "Result: FAIL"; exit 1; }
